//--- flist.f
logic/uart_bus_pkg.sv
logic/uart_line_pkg.sv
logic/uart_fifo.sv
logic/uart_fsm.sv
logic/uart_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
verification/uart_clock_gen.sv
verification/uart_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f flist.f -o uart_sim

output=$(./obj_dir/uart_sim) || true
echo "$output"

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
  exit 0
else
  exit 1
fi

//--- verification/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb
  import uart_bus_pkg::*, uart_line_pkg::*;
();

  localparam int ClockPeriod = 20;
  localparam int AckTimeout  = 8;
  localparam int ExtraBytes  = 4;
  localparam int TotalBytes  = FifoDepth + 2 + ExtraBytes;

  logic          clock;
  logic          reset;
  uart_bus_req_t req;
  logic [31:0]   rdata;
  logic          ack;
  logic          op;
  logic          txd;

  // Reference model of the register bank and both FIFOs
  logic                model_tx_en = 1'b0;
  logic                model_rx_en = 1'b0;
  logic [DivWidth-1:0] model_div = DefaultDiv;
  logic [7:0]          tx_q[$];
  logic [7:0]          rx_q[$];

  logic        read_pending = 1'b0;
  logic [2:0]  read_addr;
  logic [31:0] exp_rdata;
  logic        watchdog_armed = 1'b0;
  longint      watchdog_ns;
  int          num_checks = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  uart_clock_gen clock_gen_i (.clock, .reset);

  // Serial loopback
  uart_top #(.LITEX_ARCH(0)) dut_i (
    .clock, .reset, .req, .rdata, .ack, .op, .txd, .rxd(txd)
  );

  function automatic logic [31:0] expected_rdata(input logic [2:0] addr);
    logic [31:0] word;
    word = '0;
    case (addr)
      SiFiveTxData: word[FlagBit] = (tx_q.size() == FifoDepth);
      SiFiveRxData: begin
        if (rx_q.size() == 0) word[FlagBit] = 1'b1;
        else word[7:0] = rx_q[0];
      end
      SiFiveTxCtrl: word[0] = model_tx_en;
      SiFiveRxCtrl: word[0] = model_rx_en;
      SiFiveDiv:    word[DivWidth-1:0] = model_div;
      default:      word = '0;
    endcase
    return word;
  endfunction

  // Data accesses pass through EndOp, everything else goes straight to Final
  function automatic int access_latency(input logic is_read, input logic [2:0] addr);
    if (is_read && addr == SiFiveRxData) return 3;
    if (!is_read && addr == SiFiveTxData) return 3;
    return 2;
  endfunction

  function automatic void apply_write(input logic [2:0] addr, input logic [31:0] wdata);
    case (addr)
      SiFiveTxCtrl: model_tx_en = wdata[0];
      SiFiveRxCtrl: model_rx_en = wdata[0];
      SiFiveDiv:    model_div = wdata[DivWidth-1:0];
      SiFiveTxData: if (tx_q.size() < FifoDepth) tx_q.push_back(wdata[7:0]);
      default: ;
    endcase
  endfunction

  function automatic void deliver_sent_bytes();
    logic [7:0] b;
    if (!(model_tx_en && model_rx_en)) return;
    while (tx_q.size() > 0) begin
      b = tx_q.pop_front();
      if (rx_q.size() < FifoDepth) rx_q.push_back(b);
    end
  endfunction

  task automatic record_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errors++;
    $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
  endtask

  // Called on a falling edge, returns on a falling edge with the FSM idle
  task automatic bus_access(input logic is_read, input logic [2:0] addr,
                            input logic [31:0] wdata);
    int cycles;
    int exp_cycles;
    exp_cycles = access_latency(is_read, addr);
    read_pending = is_read;
    if (is_read) begin
      read_addr = addr;
      exp_rdata = expected_rdata(addr);
      if (addr == SiFiveRxData && rx_q.size() > 0) void'(rx_q.pop_front());
    end else begin
      apply_write(addr, wdata);
    end
    req.rd_en = is_read;
    req.wr_en = !is_read;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clock);
    req.rd_en = 1'b0;
    req.wr_en = 1'b0;
    // Access in progress
    num_checks++;
    if (op !== 1'b1) record_mismatch("op", op, 1);
    cycles = 1;
    while (!ack && cycles < AckTimeout) begin
      @(negedge clock);
      cycles++;
    end
    num_checks++;
    if (!ack) begin
      other_errors++;
      $display("ERROR: no ack within %0d cycles for access to address %0d", AckTimeout, addr);
    end else if (cycles != exp_cycles) begin
      record_mismatch($sformatf("ack latency (addr %0d)", addr), cycles, exp_cycles);
    end
    if (ack && op !== 1'b0) record_mismatch("op", op, 0);
    @(negedge clock);
    if (ack) begin
      other_errors++;
      $display("ERROR: ack stayed high for more than one cycle at %0t", $time);
    end
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] wdata);
    bus_access(1'b0, addr, wdata);
  endtask

  task automatic read_reg(input logic [2:0] addr);
    bus_access(1'b1, addr, '0);
  endtask

  // Line counts as idle after twelve bit times of steady high
  task automatic wait_line_idle();
    int high_run;
    high_run = 0;
    while (high_run < 12 * (int'(model_div) + 1)) begin
      @(negedge clock);
      if (txd) high_run++;
      else high_run = 0;
    end
  endtask

  task automatic report_and_finish();
    $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
             num_checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  always @(negedge clock) begin
    if (!reset && ack && read_pending) begin
      num_checks++;
      if (rdata !== exp_rdata) record_mismatch($sformatf("rdata (addr %0d)", read_addr),
                                               rdata, exp_rdata);
    end
  end

  initial begin
    wait (watchdog_armed);
    #(watchdog_ns);
    other_errors++;
    $display("ERROR: watchdog expired after %0d ns before the tests completed", watchdog_ns);
    report_and_finish();
  end

  initial begin
    int div_val;
    req = '0;
    void'($urandom(25));
    div_val = 3 + int'($urandom % 5);
    watchdog_ns = longint'(TotalBytes + 20) * 10 * (div_val + 1) * ClockPeriod * 2;
    watchdog_armed = 1'b1;
    @(negedge reset);
    @(negedge clock);

    num_checks += 3;
    if (ack !== 1'b0) record_mismatch("ack", ack, 0);
    if (op !== 1'b0) record_mismatch("op", op, 0);
    if (txd !== 1'b1) record_mismatch("txd", txd, 1);
    read_reg(SiFiveDiv);
    read_reg(SiFiveTxCtrl);
    read_reg(SiFiveRxCtrl);
    read_reg(3'd4);

    write_reg(SiFiveDiv, div_val);
    read_reg(SiFiveDiv);
    write_reg(SiFiveTxCtrl, $urandom | 32'd1);
    read_reg(SiFiveTxCtrl);
    write_reg(SiFiveTxCtrl, $urandom & ~32'd1);
    read_reg(SiFiveTxCtrl);
    write_reg(SiFiveRxCtrl, $urandom | 32'd1);
    read_reg(SiFiveRxCtrl);
    write_reg(SiFiveRxCtrl, $urandom & ~32'd1);
    read_reg(SiFiveRxCtrl);

    read_reg(SiFiveRxData);

    // Transmitter off, so the FIFO fills and the last two bytes are lost
    repeat (FifoDepth + 2) write_reg(SiFiveTxData, $urandom);
    read_reg(SiFiveTxData);

    write_reg(SiFiveRxCtrl, 32'd1);
    write_reg(SiFiveTxCtrl, 32'd1);
    wait_line_idle();
    deliver_sent_bytes();
    repeat (FifoDepth + 1) read_reg(SiFiveRxData);

    repeat (ExtraBytes) write_reg(SiFiveTxData, $urandom);
    wait_line_idle();
    deliver_sent_bytes();
    repeat (ExtraBytes + 1) read_reg(SiFiveRxData);
    read_reg(SiFiveTxData);

    report_and_finish();
  end

endmodule

`default_nettype wire

//--- verification/uart_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int HalfPeriod = 10;
  localparam int ResetCycles = 5;

  initial begin
    clock = 1'b0;
    forever #HalfPeriod clock = ~clock;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top
  import uart_bus_pkg::*, uart_line_pkg::*;
#(
  parameter int LITEX_ARCH = 0
) (
  input  logic          clock,
  input  logic          reset,
  input  uart_bus_req_t req,
  output logic [31:0]   rdata,
  output logic          ack,
  output logic          op,
  output logic          txd,
  input  logic          rxd
);

  logic           bank_rd_en;
  logic           bank_wr_en;
  logic           rxdata_wr_en;
  logic           tx_fifo_wr_en;
  logic           rx_fifo_rd_en;
  uart_line_cfg_t cfg;
  logic           tx_pop;
  logic [7:0]     tx_byte;
  logic           tx_byte_valid;
  logic           tx_full;
  logic           tx_empty;
  logic           rx_push;
  uart_rx_frame_t rx_frame;
  uart_rx_frame_t rx_head;
  logic           rx_head_valid;
  logic           rx_empty;

  uart_fsm #(.LITEX_ARCH(LITEX_ARCH)) fsm_i (
    .clock, .reset, .req, .op, .ack, .bank_rd_en, .bank_wr_en,
    .rxdata_wr_en, .tx_fifo_wr_en, .rx_fifo_rd_en
  );

  uart_regs #(.LITEX_ARCH(LITEX_ARCH)) regs_i (
    .clock, .reset, .req, .bank_rd_en, .bank_wr_en, .rxdata_wr_en,
    .rx_head, .rx_head_valid, .tx_full, .rx_empty, .cfg, .rdata
  );

  uart_fifo #(.payload_t(logic [7:0])) tx_fifo_i (
    .clock, .reset, .push(tx_fifo_wr_en), .wr_data(req.wdata[7:0]), .pop(tx_pop),
    .rd_data(tx_byte), .rd_valid(tx_byte_valid), .full(tx_full), .empty(tx_empty)
  );

  uart_fifo #(.payload_t(uart_rx_frame_t)) rx_fifo_i (
    .clock, .reset, .push(rx_push), .wr_data(rx_frame), .pop(rx_fifo_rd_en),
    .rd_data(rx_head), .rd_valid(rx_head_valid), .full(), .empty(rx_empty)
  );

  uart_tx tx_i (
    .clock, .reset, .cfg, .fifo_empty(tx_empty), .fifo_pop(tx_pop),
    .fifo_data(tx_byte), .fifo_valid(tx_byte_valid), .txd, .busy()
  );

  uart_rx rx_i (.clock, .reset, .cfg, .rxd, .frame_push(rx_push), .frame(rx_frame));

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_line_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  uart_line_cfg_t cfg,
  input  logic           rxd,
  output logic           frame_push,
  output uart_rx_frame_t frame
);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_t;

  rx_state_t           state;
  logic                rxd_meta;
  logic                rxd_sync;
  logic                rxd_prev;
  logic [DivWidth-1:0] cnt;
  logic [2:0]          bit_cnt;
  logic [7:0]          shreg;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      rxd_meta   <= 1'b1;
      rxd_sync   <= 1'b1;
      rxd_prev   <= 1'b1;
      state      <= RxIdle;
      cnt        <= '0;
      bit_cnt    <= '0;
      frame_push <= 1'b0;
    end else begin
      rxd_meta   <= rxd;
      rxd_sync   <= rxd_meta;
      rxd_prev   <= rxd_sync;
      frame_push <= 1'b0;
      cnt        <= cnt + 1'b1;
      case (state)
        RxIdle: begin
          cnt <= '0;
          if (cfg.rx_en && rxd_prev && !rxd_sync) state <= RxStart;
        end
        RxStart: begin
          // Mid-bit check filters glitches
          if (cnt == (cfg.div >> 1)) begin
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= rxd_sync ? RxIdle : RxData;
          end
        end
        RxData: begin
          if (cnt == cfg.div) begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RxStop;
          end
        end
        default: begin
          if (cnt == cfg.div) begin
            frame_push <= 1'b1;
            state      <= RxIdle;
          end
        end
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clock) begin
    if (state == RxData && cnt == cfg.div) shreg <= {rxd_sync, shreg[7:1]};
    if (state == RxStop && cnt == cfg.div) begin
      frame.data      <= shreg;
      frame.frame_err <= !rxd_sync;
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_line_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  uart_line_cfg_t cfg,
  input  logic           fifo_empty,
  output logic           fifo_pop,
  input  logic [7:0]     fifo_data,
  input  logic           fifo_valid,
  output logic           txd,
  output logic           busy
);

  typedef enum logic [1:0] {TxIdle, TxFetch, TxSend} tx_state_t;

  tx_state_t           state;
  logic [9:0]          shreg;
  logic [3:0]          bit_cnt;
  logic [DivWidth-1:0] div_cnt;

  assign fifo_pop = (state == TxIdle) && cfg.tx_en && !fifo_empty;
  assign busy     = state != TxIdle;
  // Ones shift in behind the frame, so the line idles high
  assign txd      = shreg[0];

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state   <= TxIdle;
      shreg   <= '1;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else begin
      case (state)
        TxIdle: if (fifo_pop) state <= TxFetch;
        TxFetch: begin
          if (fifo_valid) begin
            shreg   <= {1'b1, fifo_data, 1'b0};
            bit_cnt <= '0;
            div_cnt <= '0;
            state   <= TxSend;
          end
        end
        default: begin
          if (div_cnt == cfg.div) begin
            div_cnt <= '0;
            shreg   <= {1'b1, shreg[9:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) state <= TxIdle;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs
  import uart_bus_pkg::*, uart_line_pkg::*;
#(
  parameter int LITEX_ARCH = 0
) (
  input  logic           clock,
  input  logic           reset,
  input  uart_bus_req_t  req,
  input  logic           bank_rd_en,
  input  logic           bank_wr_en,
  input  logic           rxdata_wr_en,
  input  uart_rx_frame_t rx_head,
  input  logic           rx_head_valid,
  input  logic           tx_full,
  input  logic           rx_empty,
  output uart_line_cfg_t cfg,
  output logic [31:0]    rdata
);

  logic                tx_en_q;
  logic                rx_en_q;
  logic [DivWidth-1:0] div_q;
  uart_rx_frame_t      rx_latch;
  logic                rx_latch_valid;
  logic                rx_sel;
  logic [31:0]         rx_word;
  logic [31:0]         rd_word;
  logic [31:0]         rdata_q;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      tx_en_q        <= 1'b0;
      rx_en_q        <= 1'b0;
      div_q          <= DefaultDiv;
      rx_latch_valid <= 1'b0;
    end else begin
      if (bank_wr_en && LITEX_ARCH == 0) begin
        case (req.addr)
          SiFiveTxCtrl: tx_en_q <= req.wdata[0];
          SiFiveRxCtrl: rx_en_q <= req.wdata[0];
          SiFiveDiv:    div_q   <= req.wdata[DivWidth-1:0];
          default: ;
        endcase
      end
      if (rxdata_wr_en) rx_latch_valid <= rx_head_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (rxdata_wr_en) rx_latch <= rx_head;
    if (bank_rd_en) rdata_q <= rd_word;
  end

  // LiteX has no enable bits, the line is always on
  assign cfg.tx_en = (LITEX_ARCH != 0) || tx_en_q;
  assign cfg.rx_en = (LITEX_ARCH != 0) || rx_en_q;
  assign cfg.div   = div_q;

  // Stale FIFO output is hidden behind the empty flag
  always_comb begin
    rx_word = '0;
    if (rx_latch_valid) begin
      rx_word[7:0]         = rx_latch.data;
      rx_word[FrameErrBit] = rx_latch.frame_err;
    end else begin
      rx_word[FlagBit] = 1'b1;
    end
  end

  always_comb begin
    rd_word = '0;
    if (LITEX_ARCH != 0) begin
      if (req.addr == LitexTxFull) rd_word[0] = tx_full;
      if (req.addr == LitexRxEmpty) rd_word[0] = rx_empty;
    end else begin
      case (req.addr)
        SiFiveTxData: rd_word[FlagBit] = tx_full;
        SiFiveTxCtrl: rd_word[0] = tx_en_q;
        SiFiveRxCtrl: rd_word[0] = rx_en_q;
        SiFiveDiv:    rd_word[DivWidth-1:0] = div_q;
        default: ;
      endcase
    end
  end

  assign rx_sel = (LITEX_ARCH != 0) ? (req.addr == LitexData) : (req.addr == SiFiveRxData);
  assign rdata  = rx_sel ? rx_word : rdata_q;

endmodule

`default_nettype wire

//--- logic/uart_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fsm
  import uart_bus_pkg::*;
#(
  parameter int LITEX_ARCH = 0
) (
  input  logic          clock,
  input  logic          reset,
  input  uart_bus_req_t req,
  output logic          op,
  output logic          ack,
  output logic          bank_rd_en,
  output logic          bank_wr_en,
  output logic          rxdata_wr_en,
  output logic          tx_fifo_wr_en,
  output logic          rx_fifo_rd_en
);

  uart_fsm_t state;
  uart_fsm_t next_state;
  logic      is_tx_addr;
  logic      is_rx_addr;

  // In the LiteX map both data directions share one address
  assign is_tx_addr = (LITEX_ARCH != 0) ? (req.addr == LitexData) : (req.addr == SiFiveTxData);
  assign is_rx_addr = (LITEX_ARCH != 0) ? (req.addr == LitexData) : (req.addr == SiFiveRxData);

  always_comb begin
    next_state = Idle;
    case (state)
      Idle: begin
        if (req.rd_en) next_state = Read;
        else if (req.wr_en) next_state = Write;
      end
      Read:    next_state = is_rx_addr ? EndOp : Final;
      Write:   next_state = is_tx_addr ? EndOp : Final;
      EndOp:   next_state = Final;
      default: next_state = Idle;
    endcase
  end

  // Outputs follow the next state
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state         <= Idle;
      op            <= 1'b0;
      ack           <= 1'b0;
      bank_rd_en    <= 1'b0;
      bank_wr_en    <= 1'b0;
      rxdata_wr_en  <= 1'b0;
      tx_fifo_wr_en <= 1'b0;
    end else begin
      state         <= next_state;
      op            <= (next_state == Read) || (next_state == Write) || (next_state == EndOp);
      ack           <= next_state == Final;
      bank_rd_en    <= next_state == Read;
      bank_wr_en    <= next_state == Write;
      rxdata_wr_en  <= (next_state == EndOp) && bank_rd_en && is_rx_addr;
      tx_fifo_wr_en <= (next_state == EndOp) && bank_wr_en && is_tx_addr;
    end
  end

  // Head of rx FIFO moves to its output register during Read
  assign rx_fifo_rd_en = bank_rd_en && is_rx_addr;

  // Master side of the bus
  a_one_strobe: assert property (@(posedge clock) disable iff (reset)
    !(req.rd_en && req.wr_en));
  a_no_strobe_busy: assert property (@(posedge clock) disable iff (reset)
    op |-> !(req.rd_en || req.wr_en));
  a_ack_pulse: assert property (@(posedge clock) disable iff (reset)
    ack |=> !ack);

endmodule

`default_nettype wire

//--- logic/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
  import uart_line_pkg::*;
#(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  payload_t wr_data,
  input  logic     pop,
  output payload_t rd_data,
  output logic     rd_valid,
  output logic     full,
  output logic     empty
);

  payload_t                       mem [FifoDepth];
  logic [$clog2(FifoDepth)-1:0]   wr_ptr;
  logic [$clog2(FifoDepth)-1:0]   rd_ptr;
  logic [$clog2(FifoDepth+1)-1:0] count;
  logic                           push_ok;
  logic                           pop_ok;

  assign full    = count == FifoDepth;
  assign empty   = count == 0;
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= pop_ok;
      if (push_ok) wr_ptr <= (wr_ptr == FifoDepth - 1) ? '0 : wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= (rd_ptr == FifoDepth - 1) ? '0 : rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push_ok) mem[wr_ptr] <= wr_data;
    if (pop_ok) rd_data <= mem[rd_ptr];
  end

  a_count_bound: assert property (@(posedge clock) disable iff (reset) count <= FifoDepth);

endmodule

`default_nettype wire

//--- logic/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

  localparam int FifoDepth = 8;
  localparam int DivWidth  = 16;

  // One bit lasts div+1 clocks
  localparam logic [DivWidth-1:0] DefaultDiv = 16'd15;

  typedef struct packed {
    logic                tx_en;
    logic                rx_en;
    logic [DivWidth-1:0] div;
  } uart_line_cfg_t;

  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;
  } uart_rx_frame_t;

endpackage

`default_nettype wire

//--- logic/uart_bus_pkg.sv
`default_nettype none

package uart_bus_pkg;

  // One bus access as driven by the master
  typedef struct packed {
    logic        rd_en;
    logic        wr_en;
    logic [2:0]  addr;
    logic [31:0] wdata;
  } uart_bus_req_t;

  typedef enum logic [2:0] {
    Idle,
    Read,
    Write,
    EndOp,
    Final
  } uart_fsm_t;

  // SiFive map
  localparam logic [2:0] SiFiveTxData = 3'd0;
  localparam logic [2:0] SiFiveRxData = 3'd1;
  localparam logic [2:0] SiFiveTxCtrl = 3'd2;
  localparam logic [2:0] SiFiveRxCtrl = 3'd3;
  localparam logic [2:0] SiFiveDiv    = 3'd6;

  // LiteX map
  localparam logic [2:0] LitexData    = 3'd0;
  localparam logic [2:0] LitexTxFull  = 3'd1;
  localparam logic [2:0] LitexRxEmpty = 3'd2;

  localparam int FlagBit     = 31;
  localparam int FrameErrBit = 30;

endpackage

`default_nettype wire
